/* rtl/aes_pkg.sv */
package aes_pkg;

    //////////////////////////////////////////////////
    // Widths and counts
    //////////////////////////////////////////////////

    localparam int BLOCK_BITS = 128;
    localparam int WORD_BITS  = 32;
    localparam int BYTE_BITS  = 8;

    // Basic data types
    typedef logic [BLOCK_BITS-1:0] aes_block_t;
    typedef logic [WORD_BITS-1:0]  aes_word_t;
    typedef logic [BYTE_BITS-1:0]  aes_byte_t;

    // Enough for rounds 1 to 10
    typedef logic [3:0] round_cnt_t;

    localparam round_cnt_t NUM_ROUNDS = 4'd10;

    //////////////////////////////////////////////////
    // Field constants
    //////////////////////////////////////////////////

    // Round constant for the first expansion step
    localparam aes_byte_t RCON_FIRST = 8'h01;

    // Low byte of x^8 + x^4 + x^3 + x + 1
    localparam aes_byte_t GF_REDUCE = 8'h1b;

    // Added after the S-box inversion
    localparam aes_byte_t SBOX_AFFINE_C = 8'h63;

    //////////////////////////////////////////////////
    // Request and sequencer types
    //////////////////////////////////////////////////

    // One encryption request as held by the host
    typedef struct packed {
        aes_block_t block;
        aes_block_t key;
    } aes_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROUND,
        ST_DONE
    } ctrl_state_e;

    //////////////////////////////////////////////////
    // Field arithmetic
    //////////////////////////////////////////////////

    // Multiply by x, reduce when the top bit falls out
    function automatic aes_byte_t gf_xtime(input aes_byte_t b);
        aes_byte_t shifted;
        shifted = {b[BYTE_BITS-2:0], 1'b0};
        if (b[BYTE_BITS-1]) begin
            shifted = shifted ^ GF_REDUCE;
        end
        return shifted;
    endfunction

endpackage

/* rtl/aes_sbox.sv */
`timescale 1ns/10ps

module aes_sbox import aes_pkg::*; (
    input  aes_byte_t in,
    output aes_byte_t out
);

    // Shift-and-add product in GF(2^8)
    function automatic aes_byte_t gf_mul(input aes_byte_t a, input aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < BYTE_BITS; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = gf_xtime(sh);
        end
        return acc;
    endfunction

    //////////////////////////////////////////////////
    // Inverse as x^254, zero stays zero
    //////////////////////////////////////////////////

    aes_byte_t x2;
    aes_byte_t x3;
    aes_byte_t x12;
    aes_byte_t x15;
    aes_byte_t x240;
    aes_byte_t x252;
    aes_byte_t inv;

    always_comb begin
        x2   = gf_mul(in, in);
        x3   = gf_mul(x2, in);
        // Two squarings give x^12
        x12  = gf_mul(x3, x3);
        x12  = gf_mul(x12, x12);
        x15  = gf_mul(x12, x3);
        // Four squarings give x^240
        x240 = gf_mul(x15, x15);
        x240 = gf_mul(x240, x240);
        x240 = gf_mul(x240, x240);
        x240 = gf_mul(x240, x240);
        x252 = gf_mul(x240, x12);
        inv  = gf_mul(x252, x2);
    end

    //////////////////////////////////////////////////
    // Affine map
    //////////////////////////////////////////////////

    // Each bit sums itself and its four upper neighbours, mod 8
    assign out = inv
               ^ {inv[6:0], inv[7]}
               ^ {inv[5:0], inv[7:6]}
               ^ {inv[4:0], inv[7:5]}
               ^ {inv[3:0], inv[7:4]}
               ^ SBOX_AFFINE_C;

endmodule

/* rtl/aes_key_expand.sv */
`timescale 1ns/10ps

module aes_key_expand import aes_pkg::*; (
    input  logic       clk,
    input  logic       load,
    input  logic       step,
    input  aes_block_t key,
    output aes_block_t round_key
);

    aes_block_t key_q;
    aes_byte_t  rcon_q;

    aes_word_t  w0, w1, w2, w3;
    aes_word_t  rot_word;
    aes_byte_t  sub_byte [4];
    aes_word_t  temp;
    aes_word_t  n0, n1, n2, n3;

    assign {w0, w1, w2, w3} = key_q;

    // RotWord on the last column
    assign rot_word = {w3[WORD_BITS-BYTE_BITS-1:0], w3[WORD_BITS-1 -: BYTE_BITS]};

    // SubWord, one S-box per byte
    for (genvar i = 0; i < 4; i++) begin : g_sub
        aes_sbox u_sbox (
            .in  (rot_word[WORD_BITS-1-BYTE_BITS*i -: BYTE_BITS]),
            .out (sub_byte[i])
        );
    end

    assign temp = {sub_byte[0], sub_byte[1], sub_byte[2], sub_byte[3]}
                ^ {rcon_q, {(WORD_BITS-BYTE_BITS){1'b0}}};

    // Running XOR chain across the four columns
    assign n0 = w0 ^ temp;
    assign n1 = w1 ^ n0;
    assign n2 = w2 ^ n1;
    assign n3 = w3 ^ n2;

    assign round_key = {n0, n1, n2, n3};

    always_ff @(posedge clk) begin
        if (load) begin
            key_q  <= key;
            rcon_q <= RCON_FIRST;
        end else if (step) begin
            key_q  <= round_key;
            rcon_q <= gf_xtime(rcon_q);
        end
    end

endmodule

/* rtl/aes_round.sv */
`timescale 1ns/10ps

module aes_round import aes_pkg::*; (
    input  logic       clk,
    input  logic       load,
    input  logic       step,
    input  logic       last,
    input  aes_block_t block,
    input  aes_block_t key,
    input  aes_block_t round_key,
    output aes_block_t state
);

    // One column of MixColumns, 2a + 3b + c + d written with xtime
    function automatic aes_word_t mix_column(input aes_word_t col);
        aes_byte_t a0, a1, a2, a3;
        aes_byte_t t;
        {a0, a1, a2, a3} = col;
        t = a0 ^ a1 ^ a2 ^ a3;
        return {a0 ^ t ^ gf_xtime(a0 ^ a1),
                a1 ^ t ^ gf_xtime(a1 ^ a2),
                a2 ^ t ^ gf_xtime(a2 ^ a3),
                a3 ^ t ^ gf_xtime(a3 ^ a0)};
    endfunction

    aes_byte_t  sub_b [16];
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t next_state;

    //////////////////////////////////////////////////
    // SubBytes
    //////////////////////////////////////////////////

    for (genvar i = 0; i < 16; i++) begin : g_sub
        aes_sbox u_sbox (
            .in  (state[BLOCK_BITS-1-BYTE_BITS*i -: BYTE_BITS]),
            .out (sub_b[i])
        );
    end

    //////////////////////////////////////////////////
    // ShiftRows, MixColumns, AddRoundKey
    //////////////////////////////////////////////////

    always_comb begin
        // Byte 4c+r is row r of column c; row r rotates left by r
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[BLOCK_BITS-1-BYTE_BITS*(4*c+r) -: BYTE_BITS] =
                    sub_b[4*((c+r)%4)+r];
            end
        end

        for (int c = 0; c < 4; c++) begin
            mixed[BLOCK_BITS-1-WORD_BITS*c -: WORD_BITS] =
                mix_column(shifted[BLOCK_BITS-1-WORD_BITS*c -: WORD_BITS]);
        end

        // Final round has no MixColumns
        if (last) begin
            next_state = shifted ^ round_key;
        end else begin
            next_state = mixed ^ round_key;
        end
    end

    // Initial key whitening on load, one round per step
    always_ff @(posedge clk) begin
        if (load) begin
            state <= block ^ key;
        end else if (step) begin
            state <= next_state;
        end
    end

endmodule

/* rtl/aes_ctrl.sv */
`timescale 1ns/10ps

module aes_ctrl import aes_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic req,
    output logic ack,
    output logic load,
    output logic step,
    output logic last
);

    ctrl_state_e state_q;
    round_cnt_t  cnt_q;

    //////////////////////////////////////////////////
    // Datapath strobes
    //////////////////////////////////////////////////

    // Capture happens on the edge that sees req in idle
    assign load = (state_q == ST_IDLE) && req;
    assign step = (state_q == ST_ROUND);

    // Count holds the round being computed this cycle
    assign last = (cnt_q == NUM_ROUNDS);

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            ack     <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req) begin
                        state_q <= ST_ROUND;
                        cnt_q   <= round_cnt_t'(1);
                    end
                end

                ST_ROUND: begin
                    if (last) begin
                        // Tenth round lands in the state register now
                        state_q <= ST_DONE;
                        ack     <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + round_cnt_t'(1);
                    end
                end

                ST_DONE: begin
                    // Result held until the host lets go of req
                    if (!req) begin
                        state_q <= ST_IDLE;
                        ack     <= 1'b0;
                    end
                end

                default: begin
                    state_q <= ST_IDLE;
                    ack     <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* rtl/aes_core.sv */
`timescale 1ns/10ps

module aes_core import aes_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  aes_req_t   request,
    output logic       ack,
    output aes_block_t result
);

    logic       load;
    logic       step;
    logic       last;
    aes_block_t round_key;

    // Handshake and round sequencing
    aes_ctrl u_ctrl (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .ack  (ack),
        .load (load),
        .step (step),
        .last (last)
    );

    // Next round key, one expansion per step
    aes_key_expand u_key_expand (
        .clk       (clk),
        .load      (load),
        .step      (step),
        .key       (request.key),
        .round_key (round_key)
    );

    // State register doubles as the result
    aes_round u_round (
        .clk       (clk),
        .load      (load),
        .step      (step),
        .last      (last),
        .block     (request.block),
        .key       (request.key),
        .round_key (round_key),
        .state     (result)
    );

endmodule

/* tb/aes_core_properties.sv */
`timescale 1ns/10ps

module aes_core_properties import aes_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       req,
    input logic       ack,
    input aes_block_t result
);

    // Ack is first seen high on the eleventh sample after the capture edge
    property p_fixed_latency;
        @(posedge clk) disable iff (rst)
        ($rose(req) && !ack) |-> ##10 !ack ##1 ack;
    endproperty

    // Nothing moves while the host holds req after ack
    property p_hold_steady;
        @(posedge clk) disable iff (rst)
        (req && ack) |=> (ack && $stable(result));
    endproperty

    // The edge that sets ack must have sampled req high
    property p_ack_needs_req;
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req);
    endproperty

    a_fixed_latency: assert property (p_fixed_latency)
        else $error("ack did not rise ten cycles after the capture edge");
    a_hold_steady: assert property (p_hold_steady)
        else $error("ack or result changed while req was held high");
    a_ack_needs_req: assert property (p_ack_needs_req)
        else $error("ack rose while req was low");

endmodule

bind aes_core aes_core_properties u_properties (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .result (result)
);

/* tb/aes_core_tb.sv */
`timescale 1ns/10ps

module aes_core_tb import aes_pkg::*; ();

    //////////////////////////////////////////////////
    // Run limits
    //////////////////////////////////////////////////

    localparam int NUM_TESTS    = 4;
    localparam int ROUND_EDGES  = 10;
    // Falling edges from raising req to ack, capture plus ten rounds
    localparam int ACK_EDGES    = 1 + ROUND_EDGES;
    localparam int MAX_HOLD     = 7;
    localparam int TEST_CYCLES  = 1 + ROUND_EDGES + MAX_HOLD + 3;
    localparam int RESET_CYCLES = 3;
    localparam int CYCLE_LIMIT  = NUM_TESTS * TEST_CYCLES + RESET_CYCLES + 20;
    localparam int ACK_WAIT_LIMIT = ACK_EDGES + 4;

    logic       clk;
    logic       rst;
    logic       req;
    aes_req_t   request;
    logic       ack;
    aes_block_t result;

    int     error_count;
    int     check_count;
    int     test_errors;
    int     tests_run;
    int     tests_bad;
    int     cycle_count;
    integer seed;

    //////////////////////////////////////////////////
    // Known-answer table
    //////////////////////////////////////////////////

    string test_name [NUM_TESTS] = '{
        "zero_vector",
        "appendix_b",
        "appendix_c1",
        "zero_vector_repeat"
    };

    // Block, then key
    aes_req_t test_req [NUM_TESTS] = '{
        {128'h00000000000000000000000000000000, 128'h00000000000000000000000000000000},
        {128'h3243f6a8885a308d313198a2e0370734, 128'h2b7e151628aed2a6abf7158809cf4f3c},
        {128'h00112233445566778899aabbccddeeff, 128'h000102030405060708090a0b0c0d0e0f},
        {128'h00000000000000000000000000000000, 128'h00000000000000000000000000000000}
    };

    aes_block_t test_expect [NUM_TESTS] = '{
        128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
        128'h3925841d02dc09fbdc118597196a0b32,
        128'h69c4e0d86a7b0430d8cdb78070b4c55a,
        128'h66e94bd4ef8a2c3b884cfa59ca342b2e
    };

    aes_core DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_block(input string name, input aes_block_t expected,
                               input aes_block_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_bad++;
            $display("FAIL %s with %0d errors", name, test_errors);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequences
    //////////////////////////////////////////////////

    // ack must stay low out of reset while req is low
    task automatic check_idle();
        test_errors = 0;
        check_bit("reset ack", 1'b0, ack);
        repeat (2) begin
            @(negedge clk);
            check_bit("idle ack", 1'b0, ack);
        end
        report_test("reset_idle");
    endtask

    // Full four-phase handshake for one table row
    task automatic run_request(input int idx);
        string      name;
        int         edges;
        int         hold_cycles;
        aes_block_t held;
        name        = test_name[idx];
        test_errors = 0;
        request     = test_req[idx];
        req         = 1'b1;

        edges = 0;
        while (ack !== 1'b1 && edges < ACK_WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
            if (edges <= ACK_EDGES) begin
                check_bit({name, " ack timing"}, edges == ACK_EDGES, ack);
            end
        end

        if (ack !== 1'b1) begin
            error_count++;
            test_errors++;
            $display("%s: no ack within %0d cycles of req", name, ACK_WAIT_LIMIT);
        end else begin
            check_block({name, " result"}, test_expect[idx], result);
            held        = result;
            hold_cycles = $unsigned($random(seed)) % (MAX_HOLD + 1);
            // Host keeps req high, core must hold still
            repeat (hold_cycles) begin
                @(negedge clk);
                check_bit({name, " ack hold"}, 1'b1, ack);
                check_block({name, " result hold"}, held, result);
            end
        end

        req     = 1'b0;
        request = '0;
        @(negedge clk);
        check_bit({name, " ack release"}, 1'b0, ack);
        @(negedge clk);
        report_test(name);
    endtask

    initial begin
        seed        = 96;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        tests_run   = 0;
        tests_bad   = 0;
        rst         = 1'b1;
        req         = 1'b0;
        request     = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        check_idle();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_request(i);
        end

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* aes_core.f */
rtl/aes_pkg.sv
rtl/aes_sbox.sv
rtl/aes_key_expand.sv
rtl/aes_round.sv
rtl/aes_ctrl.sv
rtl/aes_core.sv
tb/aes_core_properties.sv
tb/aes_core_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the AES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module aes_core_tb \
    -Mdir obj_dir \
    -o aes_core_sim \
    -f aes_core.f
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

output=$(./obj_dir/aes_core_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
